//--- id_stage.f
design/id_pkg.sv
design/inst_decoder.sv
design/regfile.sv
design/operand_bypass.sv
design/branch_unit.sv
design/id_stage.sv
dv/id_stage_tb.sv

//--- Makefile
OBJ_DIR := obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run the id_stage testbench with Verilator"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --top-module id_stage_tb \
		--Mdir $(OBJ_DIR) -o id_stage_sim -f id_stage.f
	./$(OBJ_DIR)/id_stage_sim

clean:
	rm -rf $(OBJ_DIR)

//--- dv/id_stage_tb.sv
`timescale 1ns/1ns

module id_stage_tb;
  import id_pkg::*;

  typedef struct {
    if_to_id_t fetch;
    exe_fwd_t  ex;
    fwd_t      mem;
    fwd_t      wb;
    logic      allow;
    alu_op_t   alu_op;
    word_t     src1;
    word_t     src2;
    word_t     st_data;
    reg_addr_t waddr;
    logic      reg_we;
    logic      mem_we;
    logic      from_mem;
    logic      taken;
    logic      stall;
    word_t     target;
  } vec_t;

  logic       clk = 1'b0;
  logic       rst;
  logic       if_to_id_valid;
  if_to_id_t  if_to_id;
  logic       id_allowin;
  logic       exe_allowin;
  logic       id_to_exe_valid;
  id_to_exe_t id_to_exe;
  id_to_if_t  id_to_if;
  exe_fwd_t   exe_fwd;
  fwd_t       mem_fwd;
  fwd_t       wb_fwd;

  word_t      seed = 32'h17e3_30a0;
  word_t      rf_model [32];
  vec_t       tab [$];
  vec_t       cur;

  logic [16:0] ops3 [11] = '{op_add, op_sub, op_slt, op_sltu, op_nor, op_and, op_or,
                             op_xor, op_sll, op_srl, op_sra};
  int          bits3 [11] = '{0, 1, 2, 3, 5, 4, 6, 7, 8, 9, 10};
  logic [16:0] opsh [3] = '{op_slli, op_srli, op_srai};
  logic [9:0]  ops12 [8] = '{op_slti, op_sltui, op_addi, op_andi, op_ori, op_xori,
                             op_ld_w, op_st_w};
  int          bits12 [8] = '{2, 3, 0, 4, 6, 7, 0, 0};
  logic [5:0]  brops [6] = '{op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu};

  id_stage u_dut (
    .clk             (clk),
    .rst             (rst),
    .if_to_id_valid  (if_to_id_valid),
    .if_to_id        (if_to_id),
    .id_allowin      (id_allowin),
    .exe_allowin     (exe_allowin),
    .id_to_exe_valid (id_to_exe_valid),
    .id_to_exe       (id_to_exe),
    .id_to_if        (id_to_if),
    .exe_fwd         (exe_fwd),
    .mem_fwd         (mem_fwd),
    .wb_fwd          (wb_fwd)
  );

  always #5 clk = ~clk;

  function automatic word_t lcg();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  function automatic reg_addr_t rnd_reg();
    return reg_addr_t'(lcg() >> 27);
  endfunction

  function automatic word_t sext16(input logic [15:0] offs);
    return {{14{offs[15]}}, offs, 2'b0};
  endfunction

  function automatic word_t enc3r(input logic [16:0] op, input reg_addr_t rd,
                                  input reg_addr_t rj, input reg_addr_t rk);
    return {op, rk, rj, rd};
  endfunction

  function automatic word_t encbr(input logic [5:0] op, input reg_addr_t rj,
                                  input reg_addr_t rd, input logic [15:0] offs);
    return {op, offs, rj, rd};
  endfunction

  // youngest matching stage, then the register model
  function automatic word_t opnd(input reg_addr_t a);
    if (a == 0) return '0;
    if (cur.ex.valid && cur.ex.reg_we && cur.ex.waddr == a) return cur.ex.wdata;
    if (cur.mem.valid && cur.mem.reg_we && cur.mem.waddr == a) return cur.mem.wdata;
    if (cur.wb.valid && cur.wb.reg_we && cur.wb.waddr == a) return cur.wb.wdata;
    return rf_model[a];
  endfunction

  task automatic check(input string name, input logic [159:0] got, input logic [159:0] exp);
    assert (got === exp) else begin
      $display("[ERROR] %s got %h expected %h", name, got, exp);
      $display("** FAIL **");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic wait_high(input logic sel);
    int n;
    n = 0;
    #1;
    while (!(sel ? id_to_exe_valid : id_allowin)) begin
      if (n == 20) begin
        $display("timed out waiting for the stage handshake");
        $display("** FAIL **");
        $fatal(1, "timeout");
      end
      n++;
      @(negedge clk);
      #1;
    end
  endtask

  task automatic new_vec();
    cur.ex = '0;
    cur.mem = '0;
    cur.wb = '0;
    cur.allow = 1'b1;
    cur.stall = 1'b0;
    cur.st_data = '0;
    cur.fetch.pc = lcg() & ~32'h3;
  endtask

  task automatic put(input word_t inst, input int bit_idx, input word_t s1, input word_t s2,
                     input reg_addr_t wa, input logic we, input logic mw, input logic fm,
                     input logic tk, input word_t tgt);
    cur.fetch.inst = inst;
    cur.alu_op = (bit_idx < 0) ? '0 : alu_op_t'(1) << bit_idx;
    cur.src1 = s1;
    cur.src2 = s2;
    cur.waddr = wa;
    cur.reg_we = we;
    cur.mem_we = mw;
    cur.from_mem = fm;
    cur.taken = tk;
    cur.target = tgt;
    tab.push_back(cur);
    if (cur.wb.valid && cur.wb.reg_we && cur.wb.waddr != 0) rf_model[cur.wb.waddr] = cur.wb.wdata;
  endtask

  task automatic build_table();
    reg_addr_t   rd;
    reg_addr_t   rj;
    reg_addr_t   rk;
    logic [11:0] imm12;
    logic [19:0] si20;
    logic [15:0] offs;
    logic [25:0] offs26;
    word_t       inst;
    word_t       a;
    word_t       b;
    logic        c;
    for (int i = 0; i < 11; i++) begin
      new_vec();
      rd = rnd_reg();
      rj = rnd_reg();
      rk = rnd_reg();
      put(enc3r(ops3[i], rd, rj, rk), bits3[i], opnd(rj), opnd(rk), rd, 1, 0, 0, 0, 0);
    end
    for (int i = 0; i < 3; i++) begin
      new_vec();
      rd = rnd_reg();
      rj = rnd_reg();
      rk = rnd_reg();
      put(enc3r(opsh[i], rd, rj, rk), 8 + i, opnd(rj), {27'b0, rk}, rd, 1, 0, 0, 0, 0);
    end
    for (int i = 0; i < 8; i++) begin
      new_vec();
      rd = rnd_reg();
      rj = rnd_reg();
      imm12 = 12'(lcg() >> 20);
      a = (i >= 3 && i <= 5) ? {20'b0, imm12} : {{20{imm12[11]}}, imm12};
      cur.st_data = opnd(rd);
      put({ops12[i], imm12, rj, rd}, bits12[i], opnd(rj), a, rd, ops12[i] != op_st_w,
          ops12[i] == op_st_w, ops12[i] == op_ld_w, 0, 0);
    end
    new_vec();
    si20 = 20'(lcg() >> 12);
    inst = {op_lu12i, si20, 5'd4};
    put(inst, 11, rf_model[inst[9:5]], {si20, 12'b0}, 4, 1, 0, 0, 0, 0);
    new_vec();
    put({op_pcaddu12i, si20, 5'd6}, 0, cur.fetch.pc, {si20, 12'b0}, 6, 1, 0, 0, 0, 0);
    // undecoded word
    new_vec();
    put(32'hffff_ffff, -1, rf_model[31], rf_model[31], 31, 0, 0, 0, 0, 0);
    new_vec();
    put(enc3r(op_add, 5, 0, 1), 0, '0, opnd(1), 5, 1, 0, 0, 0, 0);
    // forwarding priority
    new_vec();
    cur.ex = '{1'b1, 1'b1, 1'b0, 5'd7, lcg()};
    cur.mem = '{1'b1, 1'b1, 5'd7, lcg()};
    cur.wb = '{1'b1, 1'b1, 5'd7, lcg()};
    put(enc3r(op_add, 9, 7, 3), 0, opnd(7), opnd(3), 9, 1, 0, 0, 0, 0);
    new_vec();
    cur.mem = '{1'b1, 1'b1, 5'd8, lcg()};
    cur.wb = '{1'b1, 1'b1, 5'd8, lcg()};
    put(enc3r(op_add, 9, 8, 3), 0, opnd(8), opnd(3), 9, 1, 0, 0, 0, 0);
    new_vec();
    cur.ex = '{1'b1, 1'b1, 1'b0, 5'd0, lcg()};
    cur.mem = '{1'b1, 1'b1, 5'd0, lcg()};
    cur.wb = '{1'b1, 1'b1, 5'd0, lcg()};
    put(enc3r(op_add, 9, 0, 3), 0, '0, opnd(3), 9, 1, 0, 0, 0, 0);
    // load-use on a plain op and on a branch
    new_vec();
    cur.ex = '{1'b1, 1'b1, 1'b1, 5'd10, lcg()};
    cur.stall = 1'b1;
    put(enc3r(op_add, 11, 10, 3), 0, opnd(10), opnd(3), 11, 1, 0, 0, 0, 0);
    new_vec();
    cur.ex = '{1'b1, 1'b1, 1'b1, 5'd12, lcg()};
    cur.stall = 1'b1;
    offs = 16'(lcg() >> 16);
    put(encbr(op_beq, 12, 12, offs), -1, opnd(12), opnd(12), 12, 0, 0, 0, 1,
        cur.fetch.pc + sext16(offs));
    new_vec();
    cur.allow = 1'b0;
    put(enc3r(op_sub, 13, 14, 15), 1, opnd(14), opnd(15), 13, 1, 0, 0, 0, 0);
    for (int k = 0; k < 6; k++) begin
      for (int j = 0; j < 3; j++) begin
        new_vec();
        rj = rnd_reg();
        rd = (j == 0) ? rj : rnd_reg();
        a = opnd(rj);
        b = opnd(rd);
        case (k)
          0: c = a == b;
          1: c = a != b;
          2: c = $signed(a) < $signed(b);
          3: c = $signed(a) >= $signed(b);
          4: c = a < b;
          default: c = a >= b;
        endcase
        offs = 16'(lcg() >> 16);
        put(encbr(brops[k], rj, rd, offs), -1, a, b, rd, 0, 0, 0, c,
            cur.fetch.pc + sext16(offs));
      end
    end
    new_vec();
    offs26 = 26'(lcg() >> 6);
    inst = {op_b, offs26[15:0], offs26[25:16]};
    put(inst, -1, rf_model[inst[9:5]], rf_model[inst[14:10]], inst[4:0], 0, 0, 0, 1,
        cur.fetch.pc + {{4{offs26[25]}}, offs26, 2'b0});
    new_vec();
    put({op_bl, offs26[15:0], offs26[25:16]}, 0, cur.fetch.pc, 32'd4, 1, 1, 0, 0, 1,
        cur.fetch.pc + {{4{offs26[25]}}, offs26, 2'b0});
    new_vec();
    rj = rnd_reg();
    rd = rnd_reg();
    put(encbr(op_jirl, rj, rd, offs), 0, cur.fetch.pc, 32'd4, rd, 1, 0, 0, 1,
        opnd(rj) + sext16(offs));
  endtask

  task automatic apply(input vec_t e);
    id_to_exe_t snap;
    @(negedge clk);
    exe_allowin = e.allow;
    if_to_id_valid = 1'b1;
    if_to_id = e.fetch;
    exe_fwd = e.ex;
    mem_fwd = e.mem;
    wb_fwd = e.wb;
    wait_high(1'b0);
    @(posedge clk);
    @(negedge clk);
    if_to_id_valid = 1'b0;
    check("id_to_exe_valid", id_to_exe_valid, !e.stall);
    if (e.stall) begin
      check("id_allowin", id_allowin, 1'b0);
      check("id_to_if.stall", id_to_if.stall, e.taken);
      check("id_to_if.taken", id_to_if.taken, 1'b0);
      // load moves on to mem
      exe_fwd = '0;
      mem_fwd = '{1'b1, 1'b1, e.ex.waddr, e.ex.wdata};
      wait_high(1'b1);
    end
    check("id_to_exe.alu_op", id_to_exe.alu_op, e.alu_op);
    check("id_to_exe.src1", id_to_exe.src1, e.src1);
    check("id_to_exe.src2", id_to_exe.src2, e.src2);
    check("id_to_exe.waddr", id_to_exe.waddr, e.waddr);
    check("id_to_exe.reg_we", id_to_exe.reg_we, e.reg_we);
    check("id_to_exe.mem_we", id_to_exe.mem_we, e.mem_we);
    check("id_to_exe.res_from_mem", id_to_exe.res_from_mem, e.from_mem);
    check("id_to_exe.pc", id_to_exe.pc, e.fetch.pc);
    if (e.mem_we) check("id_to_exe.st_data", id_to_exe.st_data, e.st_data);
    check("id_to_if.taken", id_to_if.taken, e.taken);
    if (e.taken) check("id_to_if.target", id_to_if.target, e.target);
    if (!e.allow) begin
      snap = id_to_exe;
      // fetch keeps offering while execute is full
      if_to_id_valid = 1'b1;
      if_to_id = {e.fetch.pc + 32'd4, enc3r(op_add, 2, 3, 4)};
      repeat (4) begin
        @(negedge clk);
        check("id_to_exe", id_to_exe, snap);
        check("id_to_exe_valid", id_to_exe_valid, 1'b1);
        check("id_allowin", id_allowin, 1'b0);
      end
      exe_allowin = 1'b1;
    end
    // offer a slot behind the instruction
    if_to_id_valid = e.taken;
    if_to_id = {e.fetch.pc + 32'd4, enc3r(op_add, 2, 3, 4)};
    @(posedge clk);
    @(negedge clk);
    if_to_id_valid = 1'b0;
    if (e.taken) check("id_to_exe_valid", id_to_exe_valid, 1'b0);
  endtask

  initial begin
    word_t v;
    rst = 1'b1;
    if_to_id_valid = 1'b0;
    if_to_id = '0;
    exe_allowin = 1'b1;
    exe_fwd = '0;
    mem_fwd = '0;
    wb_fwd = '0;
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    check("id_to_exe_valid", id_to_exe_valid, 1'b0);
    check("id_to_if.taken", id_to_if.taken, 1'b0);
    check("id_allowin", id_allowin, 1'b1);
    for (int r = 0; r < 32; r++) begin
      v = lcg();
      wb_fwd = '{1'b1, 1'b1, reg_addr_t'(r), v};
      rf_model[r] = (r == 0) ? '0 : v;
      @(negedge clk);
    end
    wb_fwd = '0;
    build_table();
    foreach (tab[i]) apply(tab[i]);
    $display("** PASS **");
    $finish;
  end

endmodule

//--- design/id_stage.sv
`timescale 1ns/1ns

module id_stage (
  input  logic               clk,
  input  logic               rst,
  input  logic               if_to_id_valid,
  input  id_pkg::if_to_id_t  if_to_id,
  output logic               id_allowin,
  input  logic               exe_allowin,
  output logic               id_to_exe_valid,
  output id_pkg::id_to_exe_t id_to_exe,
  output id_pkg::id_to_if_t  id_to_if,
  input  id_pkg::exe_fwd_t   exe_fwd,
  input  id_pkg::fwd_t       mem_fwd,
  input  id_pkg::fwd_t       wb_fwd
);
  import id_pkg::*;

  logic      id_valid;
  if_to_id_t id_data;
  dec_t      dec;
  word_t     rdata1;
  word_t     rdata2;
  word_t     opnd1;
  word_t     opnd2;
  word_t     br_target;
  logic      load_use;
  logic      ready_go;
  logic      br_cond;
  logic      br_taken;

  assign ready_go        = ~load_use;
  assign id_allowin      = ~id_valid | ready_go & exe_allowin;
  assign id_to_exe_valid = id_valid & ready_go;
  assign br_taken        = id_to_exe_valid & br_cond;

  always_ff @(posedge clk) begin
    if (rst) begin
      id_valid <= 1'b0;
    end else if (br_taken && exe_allowin) begin
      // drop the slot behind a taken branch
      id_valid <= 1'b0;
    end else if (id_allowin) begin
      id_valid <= if_to_id_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (id_allowin && if_to_id_valid) begin
      id_data <= if_to_id;
    end
  end

  inst_decoder u_dec (
    .inst (id_data.inst),
    .dec  (dec)
  );

  regfile u_rf (
    .clk    (clk),
    .raddr1 (dec.raddr1),
    .raddr2 (dec.raddr2),
    .rdata1 (rdata1),
    .rdata2 (rdata2),
    .wr     (wb_fwd)
  );

  operand_bypass u_byp (
    .dec      (dec),
    .id_valid (id_valid),
    .rdata1   (rdata1),
    .rdata2   (rdata2),
    .exe_fwd  (exe_fwd),
    .mem_fwd  (mem_fwd),
    .wb_fwd   (wb_fwd),
    .opnd1    (opnd1),
    .opnd2    (opnd2),
    .load_use (load_use)
  );

  branch_unit u_br (
    .br_kind (dec.br_kind),
    .pc      (id_data.pc),
    .br_offs (dec.br_offs),
    .opnd1   (opnd1),
    .opnd2   (opnd2),
    .cond    (br_cond),
    .target  (br_target)
  );

  assign id_to_exe.alu_op       = dec.alu_op;
  assign id_to_exe.res_from_mem = dec.res_from_mem;
  assign id_to_exe.reg_we       = dec.reg_we;
  assign id_to_exe.mem_we       = dec.mem_we;
  assign id_to_exe.waddr        = dec.waddr;
  assign id_to_exe.st_data      = opnd2;
  assign id_to_exe.src1         = dec.src1_is_pc ? id_data.pc : opnd1;
  assign id_to_exe.src2         = dec.src2_is_imm ? dec.imm : opnd2;
  assign id_to_exe.pc           = id_data.pc;

  // fetch waits while a taken branch sits on a load
  assign id_to_if.stall  = id_valid & load_use & br_cond;
  assign id_to_if.taken  = br_taken;
  assign id_to_if.target = br_target;

endmodule

//--- design/branch_unit.sv
`timescale 1ns/1ns

module branch_unit (
  input  id_pkg::br_kind_e br_kind,
  input  id_pkg::word_t    pc,
  input  id_pkg::word_t    br_offs,
  input  id_pkg::word_t    opnd1,
  input  id_pkg::word_t    opnd2,
  output logic             cond,
  output id_pkg::word_t    target
);
  import id_pkg::*;

  word_t diff;
  logic  carry;
  logic  eq;
  logic  lt;
  logic  ltu;

  // a - b as a + ~b + 1, borrow is the inverted carry
  assign {carry, diff} = {1'b0, opnd1} + {1'b0, ~opnd2} + 33'd1;

  assign eq  = diff == '0;
  assign ltu = ~carry;
  assign lt  = (opnd1[xlen-1] & ~opnd2[xlen-1])
             | (~(opnd1[xlen-1] ^ opnd2[xlen-1]) & diff[xlen-1]);

  always_comb begin
    case (br_kind)
      br_beq:    cond = eq;
      br_bne:    cond = ~eq;
      br_blt:    cond = lt;
      br_bge:    cond = ~lt;
      br_bltu:   cond = ltu;
      br_bgeu:   cond = ~ltu;
      br_direct: cond = 1'b1;
      br_jirl:   cond = 1'b1;
      default:   cond = 1'b0;
    endcase
  end

  assign target = ((br_kind == br_jirl) ? opnd1 : pc) + br_offs;

endmodule

//--- design/operand_bypass.sv
`timescale 1ns/1ns

module operand_bypass (
  input  id_pkg::dec_t     dec,
  input  logic             id_valid,
  input  id_pkg::word_t    rdata1,
  input  id_pkg::word_t    rdata2,
  input  id_pkg::exe_fwd_t exe_fwd,
  input  id_pkg::fwd_t     mem_fwd,
  input  id_pkg::fwd_t     wb_fwd,
  output id_pkg::word_t    opnd1,
  output id_pkg::word_t    opnd2,
  output logic             load_use
);
  import id_pkg::*;

  logic use1;
  logic use2;
  logic exe_hit1;
  logic exe_hit2;

  // youngest matching writer wins
  function automatic word_t pick(input logic use_src, input reg_addr_t addr,
                                 input word_t rf_data, input exe_fwd_t ex,
                                 input fwd_t mem, input fwd_t wb);
    word_t res;
    res = rf_data;
    if (use_src) begin
      if (ex.valid && ex.reg_we && ex.waddr == addr) res = ex.wdata;
      else if (mem.valid && mem.reg_we && mem.waddr == addr) res = mem.wdata;
      else if (wb.valid && wb.reg_we && wb.waddr == addr) res = wb.wdata;
    end
    return res;
  endfunction

  assign use1 = dec.need_rj && dec.raddr1 != '0;
  assign use2 = dec.need_rkd && dec.raddr2 != '0;

  assign opnd1 = pick(use1, dec.raddr1, rdata1, exe_fwd, mem_fwd, wb_fwd);
  assign opnd2 = pick(use2, dec.raddr2, rdata2, exe_fwd, mem_fwd, wb_fwd);

  // load data is not ready until mem
  assign exe_hit1 = use1 && exe_fwd.waddr == dec.raddr1;
  assign exe_hit2 = use2 && exe_fwd.waddr == dec.raddr2;
  assign load_use = id_valid && exe_fwd.valid && exe_fwd.is_load && (exe_hit1 || exe_hit2);

endmodule

//--- design/regfile.sv
`timescale 1ns/1ns

module regfile (
  input  logic              clk,
  input  id_pkg::reg_addr_t raddr1,
  input  id_pkg::reg_addr_t raddr2,
  output id_pkg::word_t     rdata1,
  output id_pkg::word_t     rdata2,
  input  id_pkg::fwd_t      wr
);
  import id_pkg::*;

  word_t regs [reg_num];

  always_ff @(posedge clk) begin
    if (wr.valid && wr.reg_we) begin
      regs[wr.waddr] <= wr.wdata;
    end
  end

  // r0 is hardwired
  assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
  assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

//--- design/inst_decoder.sv
`timescale 1ns/1ns

module inst_decoder (
  input  id_pkg::word_t inst,
  output id_pkg::dec_t  dec
);
  import id_pkg::*;

  logic [16:0] op_3r;
  logic [9:0]  op_12;
  logic [6:0]  op_20;
  logic [5:0]  op_6;
  reg_addr_t   rd;
  reg_addr_t   rj;
  reg_addr_t   rk;

  logic inst_add, inst_sub, inst_slt, inst_sltu, inst_nor, inst_and;
  logic inst_or, inst_xor, inst_sll, inst_srl, inst_sra;
  logic inst_slli, inst_srli, inst_srai;
  logic inst_slti, inst_sltui, inst_addi, inst_andi, inst_ori, inst_xori;
  logic inst_ld_w, inst_st_w, inst_lu12i, inst_pcaddu12i;
  logic inst_jirl, inst_b, inst_bl;
  logic inst_beq, inst_bne, inst_blt, inst_bge, inst_bltu, inst_bgeu;
  logic is_3r, is_shift_imm, is_cond_br, is_link;
  logic need_si20, need_si12, need_ui12;

  assign op_3r = inst[31:15];
  assign op_12 = inst[31:22];
  assign op_20 = inst[31:25];
  assign op_6  = inst[31:26];
  assign rd    = inst[4:0];
  assign rj    = inst[9:5];
  assign rk    = inst[14:10];

  assign inst_add       = op_3r == op_add;
  assign inst_sub       = op_3r == op_sub;
  assign inst_slt       = op_3r == op_slt;
  assign inst_sltu      = op_3r == op_sltu;
  assign inst_nor       = op_3r == op_nor;
  assign inst_and       = op_3r == op_and;
  assign inst_or        = op_3r == op_or;
  assign inst_xor       = op_3r == op_xor;
  assign inst_sll       = op_3r == op_sll;
  assign inst_srl       = op_3r == op_srl;
  assign inst_sra       = op_3r == op_sra;
  assign inst_slli      = op_3r == op_slli;
  assign inst_srli      = op_3r == op_srli;
  assign inst_srai      = op_3r == op_srai;
  assign inst_slti      = op_12 == op_slti;
  assign inst_sltui     = op_12 == op_sltui;
  assign inst_addi      = op_12 == op_addi;
  assign inst_andi      = op_12 == op_andi;
  assign inst_ori       = op_12 == op_ori;
  assign inst_xori      = op_12 == op_xori;
  assign inst_ld_w      = op_12 == op_ld_w;
  assign inst_st_w      = op_12 == op_st_w;
  assign inst_lu12i     = op_20 == op_lu12i;
  assign inst_pcaddu12i = op_20 == op_pcaddu12i;
  assign inst_jirl      = op_6 == op_jirl;
  assign inst_b         = op_6 == op_b;
  assign inst_bl        = op_6 == op_bl;
  assign inst_beq       = op_6 == op_beq;
  assign inst_bne       = op_6 == op_bne;
  assign inst_blt       = op_6 == op_blt;
  assign inst_bge       = op_6 == op_bge;
  assign inst_bltu      = op_6 == op_bltu;
  assign inst_bgeu      = op_6 == op_bgeu;

  assign is_3r = inst_add | inst_sub | inst_slt | inst_sltu | inst_nor | inst_and
               | inst_or | inst_xor | inst_sll | inst_srl | inst_sra;
  assign is_shift_imm = inst_slli | inst_srli | inst_srai;
  assign is_cond_br   = inst_beq | inst_bne | inst_blt | inst_bge | inst_bltu | inst_bgeu;
  // jirl and bl write pc + 4
  assign is_link      = inst_jirl | inst_bl;
  assign need_si20    = inst_lu12i | inst_pcaddu12i;
  assign need_si12    = inst_addi | inst_slti | inst_sltui | inst_ld_w | inst_st_w;
  assign need_ui12    = inst_andi | inst_ori | inst_xori;

  assign dec.alu_op = {
    inst_lu12i,
    inst_sra | inst_srai,
    inst_srl | inst_srli,
    inst_sll | inst_slli,
    inst_xor | inst_xori,
    inst_or | inst_ori,
    inst_nor,
    inst_and | inst_andi,
    inst_sltu | inst_sltui,
    inst_slt | inst_slti,
    inst_sub,
    inst_add | inst_addi | inst_ld_w | inst_st_w | is_link | inst_pcaddu12i
  };

  assign dec.br_kind = inst_beq  ? br_beq :
                       inst_bne  ? br_bne :
                       inst_blt  ? br_blt :
                       inst_bge  ? br_bge :
                       inst_bltu ? br_bltu :
                       inst_bgeu ? br_bgeu :
                       (inst_b | inst_bl) ? br_direct :
                       inst_jirl ? br_jirl : br_none;

  assign dec.src1_is_pc   = is_link | inst_pcaddu12i;
  assign dec.src2_is_imm  = is_shift_imm | need_si12 | need_ui12 | need_si20 | is_link;
  assign dec.res_from_mem = inst_ld_w;
  assign dec.mem_we       = inst_st_w;
  assign dec.reg_we       = is_3r | is_shift_imm | need_si12 & ~inst_st_w | need_ui12
                          | need_si20 | is_link;

  // stores and compares take rd as the second source
  assign dec.raddr1   = rj;
  assign dec.raddr2   = (is_cond_br | inst_st_w) ? rd : rk;
  assign dec.waddr    = inst_bl ? reg_addr_t'(1) : rd;
  assign dec.need_rj  = is_3r | is_shift_imm | need_si12 | need_ui12 | inst_jirl | is_cond_br;
  assign dec.need_rkd = is_3r | inst_st_w | is_cond_br;

  assign dec.imm = is_link   ? word_t'(4) :
                   need_si20 ? {inst[24:5], 12'b0} :
                   need_si12 ? {{20{inst[21]}}, inst[21:10]} :
                   need_ui12 ? {20'b0, inst[21:10]} :
                   {27'b0, rk};

  assign dec.br_offs = (inst_b | inst_bl) ? {{4{inst[9]}}, inst[9:0], inst[25:10], 2'b0}
                                          : {{14{inst[25]}}, inst[25:10], 2'b0};

endmodule

//--- design/id_pkg.sv
package id_pkg;

  localparam int xlen       = 32;
  localparam int reg_addr_w = 5;
  localparam int reg_num    = 32;

  typedef logic [xlen-1:0]       word_t;
  typedef logic [reg_addr_w-1:0] reg_addr_t;
  // one-hot: add sub slt sltu and nor or xor sll srl sra lui
  typedef logic [11:0]           alu_op_t;

  // 3r ops, inst[31:15]
  localparam logic [16:0] op_add  = 17'h00020;
  localparam logic [16:0] op_sub  = 17'h00022;
  localparam logic [16:0] op_slt  = 17'h00024;
  localparam logic [16:0] op_sltu = 17'h00025;
  localparam logic [16:0] op_nor  = 17'h00028;
  localparam logic [16:0] op_and  = 17'h00029;
  localparam logic [16:0] op_or   = 17'h0002a;
  localparam logic [16:0] op_xor  = 17'h0002b;
  localparam logic [16:0] op_sll  = 17'h0002e;
  localparam logic [16:0] op_srl  = 17'h0002f;
  localparam logic [16:0] op_sra  = 17'h00030;
  localparam logic [16:0] op_slli = 17'h00081;
  localparam logic [16:0] op_srli = 17'h00089;
  localparam logic [16:0] op_srai = 17'h00091;

  // 2ri12 ops, inst[31:22]
  localparam logic [9:0] op_slti  = 10'h008;
  localparam logic [9:0] op_sltui = 10'h009;
  localparam logic [9:0] op_addi  = 10'h00a;
  localparam logic [9:0] op_andi  = 10'h00d;
  localparam logic [9:0] op_ori   = 10'h00e;
  localparam logic [9:0] op_xori  = 10'h00f;
  localparam logic [9:0] op_ld_w  = 10'h0a2;
  localparam logic [9:0] op_st_w  = 10'h0a6;

  // 1ri20 ops, inst[31:25]
  localparam logic [6:0] op_lu12i     = 7'h0a;
  localparam logic [6:0] op_pcaddu12i = 7'h0e;

  // branch ops, inst[31:26]
  localparam logic [5:0] op_jirl = 6'h13;
  localparam logic [5:0] op_b    = 6'h14;
  localparam logic [5:0] op_bl   = 6'h15;
  localparam logic [5:0] op_beq  = 6'h16;
  localparam logic [5:0] op_bne  = 6'h17;
  localparam logic [5:0] op_blt  = 6'h18;
  localparam logic [5:0] op_bge  = 6'h19;
  localparam logic [5:0] op_bltu = 6'h1a;
  localparam logic [5:0] op_bgeu = 6'h1b;

  typedef enum logic [3:0] {
    br_none,
    br_beq,
    br_bne,
    br_blt,
    br_bge,
    br_bltu,
    br_bgeu,
    br_direct,
    br_jirl
  } br_kind_e;

  typedef struct packed {
    word_t pc;
    word_t inst;
  } if_to_id_t;

  typedef struct packed {
    logic      valid;
    logic      reg_we;
    logic      is_load;
    reg_addr_t waddr;
    word_t     wdata;
  } exe_fwd_t;

  typedef struct packed {
    logic      valid;
    logic      reg_we;
    reg_addr_t waddr;
    word_t     wdata;
  } fwd_t;

  typedef struct packed {
    alu_op_t   alu_op;
    br_kind_e  br_kind;
    logic      src1_is_pc;
    logic      src2_is_imm;
    logic      res_from_mem;
    logic      mem_we;
    logic      reg_we;
    reg_addr_t raddr1;
    reg_addr_t raddr2;
    reg_addr_t waddr;
    logic      need_rj;
    logic      need_rkd;
    word_t     imm;
    word_t     br_offs;
  } dec_t;

  typedef struct packed {
    alu_op_t   alu_op;
    logic      res_from_mem;
    logic      reg_we;
    logic      mem_we;
    reg_addr_t waddr;
    word_t     st_data;
    word_t     src1;
    word_t     src2;
    word_t     pc;
  } id_to_exe_t;

  typedef struct packed {
    logic  stall;
    logic  taken;
    word_t target;
  } id_to_if_t;

endpackage
